/* src/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// PC after reset at the boot ROM entry
`define FETCH_RESET_PC 32'h3000_0000

// Cached SDRAM window with inclusive base and exclusive limit
`define SDRAM_BASE 32'ha000_0000
`define SDRAM_LIMIT 32'ha200_0000

// Direct-mapped cache geometry
`define ICACHE_SETS 16
`define BLOCK_WORDS 4

// arlen of a block read as beats minus one
`define BURST_LEN_FIELD 4'd3

`endif

/* src/fetch_pkg.sv */
package fetch_pkg;

	typedef logic [31:0] addr_t;      // Byte address
	typedef logic [31:0] word_t;      // Instruction or data word
	typedef logic [1:0] burst_t;      // 0 fixed, 1 incrementing
	typedef logic [3:0] len_t;        // Beats minus one
	typedef logic [1:0] resp_t;
	typedef logic [23:0] cache_tag_t; // Address bits above index and offset

	// Block fill sequencing in the instruction cache
	typedef enum logic {
		fill_idle,
		fill_filling
	} fill_state_t;

endpackage

/* src/inst_cache.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_cache (
	input  logic             clock,
	input  logic             reset,

	input  fetch_pkg::addr_t lookup_addr,
	input  logic             lookup_valid,
	output logic             hit,
	output fetch_pkg::word_t hit_data,

	input  fetch_pkg::addr_t fill_addr,
	input  fetch_pkg::word_t fill_data,
	input  logic             fill_valid
);
	import fetch_pkg::*;

	localparam int OFF_W = $clog2(`BLOCK_WORDS);
	localparam int IDX_W = $clog2(`ICACHE_SETS);
	localparam int IDX_LSB = 2 + OFF_W;
	localparam int TAG_LSB = IDX_LSB + IDX_W;

	word_t data_mem [`ICACHE_SETS][`BLOCK_WORDS];
	cache_tag_t tag_mem [`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] valid_bits;

	fill_state_t state;
	logic [31:IDX_LSB] fill_block; // Block being filled

	logic [IDX_W-1:0] lk_idx;
	logic [OFF_W-1:0] lk_off;
	cache_tag_t lk_tag;
	logic [IDX_W-1:0] fl_idx;
	logic [OFF_W-1:0] fl_off;
	cache_tag_t fl_tag;
	logic fl_last;

	assign lk_idx = lookup_addr[TAG_LSB-1:IDX_LSB];
	assign lk_off = lookup_addr[IDX_LSB-1:2];
	assign lk_tag = lookup_addr[31:TAG_LSB];

	assign fl_idx = fill_addr[TAG_LSB-1:IDX_LSB];
	assign fl_off = fill_addr[IDX_LSB-1:2];
	assign fl_tag = fill_addr[31:TAG_LSB];
	assign fl_last = (fl_off == OFF_W'(`BLOCK_WORDS - 1));

	assign hit = lookup_valid & valid_bits[lk_idx] & (tag_mem[lk_idx] == lk_tag);
	assign hit_data = data_mem[lk_idx][lk_off];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fill_idle;
			valid_bits <= '0;
		end else if (fill_valid) begin
			if (fl_last) begin
				valid_bits[fl_idx] <= 1'b1;
				state <= fill_idle;
			end else if (state == fill_idle) begin
				valid_bits[fl_idx] <= 1'b0; // Old block gone from first beat
				state <= fill_filling;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[fl_idx][fl_off] <= fill_data;
			if (fl_last) begin
				tag_mem[fl_idx] <= fl_tag;
			end
			if (state == fill_idle) begin
				fill_block <= fill_addr[31:IDX_LSB];
			end
		end
	end

	a_fill_one_block: assert property (@(posedge clock) disable iff (reset)
		fill_valid && state == fill_filling |-> fill_addr[31:IDX_LSB] == fill_block);

	// Fetch side never looks up while a fill beat is written
	a_no_overlap: assert property (@(posedge clock) disable iff (reset)
		!(lookup_valid && fill_valid));

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit (
	input  logic              clock,
	input  logic              reset,

	output fetch_pkg::addr_t  araddr,
	output logic              arvalid,
	input  logic              arready,
	output fetch_pkg::burst_t arburst,
	output fetch_pkg::len_t   arlen,
	input  fetch_pkg::word_t  rdata,
	input  fetch_pkg::resp_t  rresp,
	input  logic              rlast,
	input  logic              rvalid,
	output logic              rready,

	output fetch_pkg::addr_t  lookup_addr,
	output logic              lookup_valid,
	input  logic              hit,
	input  fetch_pkg::word_t  hit_data,

	output fetch_pkg::addr_t  fill_addr,
	output fetch_pkg::word_t  fill_data,
	output logic              fill_valid,

	input  logic              jump_wrong,
	input  fetch_pkg::addr_t  jump_addr,
	output fetch_pkg::addr_t  pc,
	output fetch_pkg::word_t  inst,
	output logic              idu_valid,
	input  logic              idu_ready
);
	import fetch_pkg::*;

	localparam int OFF_W = $clog2(`BLOCK_WORDS);
	localparam addr_t BLOCK_MASK = ~addr_t'(`BLOCK_WORDS * 4 - 1);

	logic pc_in_sdram;
	logic npc_in_sdram;
	logic beat;
	logic fetch_done;
	logic handoff;
	logic redirect;
	logic fetch_go;
	logic last;
	logic jump_pending;
	logic [OFF_W-1:0] beat_off;
	addr_t pc_next;
	word_t inst_next;

	function automatic logic in_window(addr_t a);
		in_window = (a >= `SDRAM_BASE) && (a < `SDRAM_LIMIT);
	endfunction

	assign rready = 1'b1; // Every rvalid cycle is a beat
	assign beat = rvalid & rready;
	// rresp is accepted but not checked

	assign pc_in_sdram = in_window(pc);
	assign npc_in_sdram = in_window(pc_next);

	assign araddr = pc_in_sdram ? (pc & BLOCK_MASK) : pc;
	assign arburst = pc_in_sdram ? burst_t'(1) : burst_t'(0);
	assign arlen = pc_in_sdram ? `BURST_LEN_FIELD : len_t'(0);

	assign lookup_addr = pc;

	// Hit, last fill beat, or the single uncached beat
	assign fetch_done = (lookup_valid & hit) | (fill_valid & last) | (beat & ~pc_in_sdram);

	assign handoff = idu_valid & idu_ready;
	assign redirect = (jump_wrong | jump_pending) & (idu_valid | fetch_done);
	assign fetch_go = handoff | redirect;

	always_comb begin
		if (redirect) begin
			pc_next = jump_addr;
		end else if (handoff) begin
			pc_next = pc + 32'd4;
		end else begin
			pc_next = pc;
		end
	end

	always_comb begin
		if (beat & (~pc_in_sdram | (pc[OFF_W+1:2] == beat_off))) begin
			inst_next = rdata;
		end else if (lookup_valid & hit) begin
			inst_next = hit_data;
		end else begin
			inst_next = inst;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `FETCH_RESET_PC;
			arvalid <= 1'b1; // Boot fetch requested at once
			lookup_valid <= 1'b0;
			fill_valid <= 1'b0;
			last <= 1'b0;
			beat_off <= '0;
			idu_valid <= 1'b0;
			jump_pending <= 1'b0;
		end else begin
			pc <= pc_next;
			arvalid <= (arvalid & ~arready) |
				(~arvalid & ((lookup_valid & ~hit) | (fetch_go & ~npc_in_sdram)));
			lookup_valid <= fetch_go & npc_in_sdram;
			fill_valid <= beat & pc_in_sdram;
			if (beat) begin
				last <= rlast;
			end
			if (lookup_valid) begin
				beat_off <= '0;
			end else if (beat & pc_in_sdram) begin
				beat_off <= beat_off + 1'b1;
			end
			// Drop a completed fetch when a redirect is due
			idu_valid <= (~idu_valid & fetch_done & ~jump_wrong & ~jump_pending) |
				(idu_valid & ~idu_ready & ~jump_wrong);
			jump_pending <= (jump_pending & ~fetch_done) |
				(~jump_pending & jump_wrong & ~fetch_done & ~idu_valid);
		end
	end

	always_ff @(posedge clock) begin
		inst <= inst_next;
		if (beat) begin
			fill_data <= rdata;
			fill_addr <= (pc & BLOCK_MASK) | addr_t'({beat_off, 2'b00});
		end
	end

	a_ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// Stalled instruction must not change under the decoder
	a_idu_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready && !jump_wrong |=> idu_valid && $stable(inst));

endmodule

/* src/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input  logic              clock,
	input  logic              reset,

	output fetch_pkg::addr_t  araddr,
	output logic              arvalid,
	input  logic              arready,
	output fetch_pkg::burst_t arburst,
	output fetch_pkg::len_t   arlen,
	input  fetch_pkg::word_t  rdata,
	input  fetch_pkg::resp_t  rresp,
	input  logic              rlast,
	input  logic              rvalid,
	output logic              rready,

	input  logic              jump_wrong,
	input  fetch_pkg::addr_t  jump_addr,
	output fetch_pkg::addr_t  pc,
	output fetch_pkg::word_t  inst,
	output logic              idu_valid,
	input  logic              idu_ready
);
	import fetch_pkg::*;

	addr_t lookup_addr;
	logic lookup_valid;
	logic hit;
	word_t hit_data;
	addr_t fill_addr;
	word_t fill_data;
	logic fill_valid;

	fetch_unit fetch0 (
		.clock        (clock),
		.reset        (reset),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.arburst      (arburst),
		.arlen        (arlen),
		.rdata        (rdata),
		.rresp        (rresp),
		.rlast        (rlast),
		.rvalid       (rvalid),
		.rready       (rready),
		.lookup_addr  (lookup_addr),
		.lookup_valid (lookup_valid),
		.hit          (hit),
		.hit_data     (hit_data),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_valid   (fill_valid),
		.jump_wrong   (jump_wrong),
		.jump_addr    (jump_addr),
		.pc           (pc),
		.inst         (inst),
		.idu_valid    (idu_valid),
		.idu_ready    (idu_ready)
	);

	inst_cache cache0 (
		.clock        (clock),
		.reset        (reset),
		.lookup_addr  (lookup_addr),
		.lookup_valid (lookup_valid),
		.hit          (hit),
		.hit_data     (hit_data),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_valid   (fill_valid)
	);

endmodule

/* verif/bus_mem_model.sv */
`timescale 1ns/1ps

module bus_mem_model (
	input  logic              clock,
	input  logic              reset,
	input  fetch_pkg::addr_t  araddr,
	input  logic              arvalid,
	output logic              arready,
	input  fetch_pkg::burst_t arburst,
	input  fetch_pkg::len_t   arlen,
	output fetch_pkg::word_t  rdata,
	output fetch_pkg::resp_t  rresp,
	output logic              rlast,
	output logic              rvalid,
	input  logic              rready
);
	import fetch_pkg::*;

	integer seed;
	int req_count;
	addr_t last_araddr;
	burst_t last_arburst;
	len_t last_arlen;

	logic busy;
	addr_t beat_addr;
	len_t beats_left;
	burst_t cur_burst;
	int a_wait;
	int r_wait;

	function automatic int pick_delay();
		pick_delay = $unsigned($random(seed)) % 4; // 0 to 3 cycles
	endfunction

	initial begin
		seed = 32'hcec3;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		rresp = '0;
		a_wait = 0;
		r_wait = 0;
	end

	// Request and beat bookkeeping on the active edge
	always @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			req_count <= 0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				busy <= 1'b1;
				beat_addr <= araddr;
				beats_left <= arlen;
				cur_burst <= arburst;
				req_count <= req_count + 1;
				last_araddr <= araddr;
				last_arburst <= arburst;
				last_arlen <= arlen;
			end
		end else if (rvalid && rready) begin
			if (beats_left == 0) begin
				busy <= 1'b0;
			end else begin
				beats_left <= beats_left - 1'b1;
				if (cur_burst == burst_t'(1)) begin
					beat_addr <= beat_addr + 32'd4;
				end
			end
		end
	end

	// Outputs change on the falling edge only
	always @(negedge clock) begin
		if (reset) begin
			arready = 1'b0;
			rvalid = 1'b0;
			rlast = 1'b0;
			a_wait = pick_delay();
			r_wait = 0;
		end else if (!busy) begin
			rvalid = 1'b0;
			rlast = 1'b0;
			if (arvalid && !arready) begin
				if (a_wait == 0) begin
					arready = 1'b1;
					a_wait = pick_delay();
					r_wait = pick_delay();
				end else begin
					a_wait--;
				end
			end else begin
				arready = 1'b0;
			end
		end else begin
			arready = 1'b0;
			if (r_wait == 0) begin
				rvalid = 1'b1;
				rdata = beat_addr ^ 32'h5a5a_5a5a;
				rlast = (beats_left == 0);
				r_wait = pick_delay();
			end else begin
				rvalid = 1'b0;
				rlast = 1'b0;
				r_wait--;
			end
		end
	end

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam word_t MEM_KEY = 32'h5a5a_5a5a;
	localparam int ROWS = 7;

	typedef struct {
		string name;
		logic do_jump;
		addr_t start;
		int count;
		logic [7:0] stall_mask;
		int redir_at;
		int redir_mode; // 0 none, 1 while presented, 2 while fetching
		addr_t redir_addr;
		logic check_miss;
		logic check_no_req;
	} scenario_t;

	scenario_t rows [ROWS];

	logic clock;
	logic reset;
	addr_t araddr;
	logic arvalid;
	logic arready;
	burst_t arburst;
	len_t arlen;
	word_t rdata;
	resp_t rresp;
	logic rlast;
	logic rvalid;
	logic rready;
	logic jump_wrong;
	addr_t jump_addr;
	addr_t pc;
	word_t inst;
	logic idu_valid;
	logic idu_ready;

	int errors;
	addr_t exp_pc;

	always #5 clock = ~clock;

	fetch_top dut0 (
		.clock(clock), .reset(reset),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.jump_wrong(jump_wrong), .jump_addr(jump_addr),
		.pc(pc), .inst(inst), .idu_valid(idu_valid), .idu_ready(idu_ready)
	);

	bus_mem_model mem0 (
		.clock(clock), .reset(reset),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
	);

	function automatic logic in_sdram(addr_t a);
		in_sdram = (a >= `SDRAM_BASE) && (a < `SDRAM_LIMIT);
	endfunction

	task automatic set_row(int r, string name, logic do_jump, addr_t start, int count,
			logic [7:0] stall_mask, int redir_at, int redir_mode, addr_t redir_addr,
			logic check_miss, logic check_no_req);
		rows[r] = '{name, do_jump, start, count, stall_mask, redir_at, redir_mode,
			redir_addr, check_miss, check_no_req};
	endtask

	task automatic stop_with_fail();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(string test, string what, logic [31:0] exp, logic [31:0] act);
		errors++;
		$display("** Error: %s %s expected %h actual %h", test, what, exp, act);
		stop_with_fail();
	endtask

	task automatic wait_for_valid(string test);
		int n;
		n = 0;
		while (!idu_valid) begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT) begin
				errors++;
				$display("Timeout in %s, no instruction reached the decoder", test);
				stop_with_fail();
			end
		end
	endtask

	// Redirect with the decoder not accepting in the same cycle
	task automatic pulse_jump(addr_t target);
		jump_addr = target;
		jump_wrong = 1'b1;
		idu_ready = 1'b0;
		@(negedge clock);
		jump_wrong = 1'b0;
	endtask

	task automatic check_hold(string test, int cycles);
		for (int k = 0; k < cycles; k++) begin
			@(negedge clock);
			assert (idu_valid) else report_value(test, "idu_valid held", 1, 32'(idu_valid));
			assert (pc == exp_pc) else report_value(test, "pc held", exp_pc, pc);
			assert (inst == (exp_pc ^ MEM_KEY))
				else report_value(test, "inst held", exp_pc ^ MEM_KEY, inst);
		end
	endtask

	task automatic run_row(int r);
		scenario_t s;
		int start_count;
		s = rows[r];
		if (s.do_jump) begin
			wait_for_valid(s.name);
			pulse_jump(s.start);
		end
		exp_pc = s.start;
		start_count = mem0.req_count;
		for (int i = 0; i < s.count; i++) begin
			wait_for_valid(s.name);
			if (s.check_miss && i == 0) begin
				assert (mem0.last_araddr == (exp_pc & ~32'hf))
					else report_value(s.name, "block araddr", exp_pc & ~32'hf, mem0.last_araddr);
				assert (mem0.last_arlen == 4'd3)
					else report_value(s.name, "arlen", 3, 32'(mem0.last_arlen));
				assert (mem0.last_arburst == 2'd1)
					else report_value(s.name, "arburst", 1, 32'(mem0.last_arburst));
			end
			if (!in_sdram(exp_pc)) begin // Single beat outside the window
				assert (mem0.last_arlen == 4'd0)
					else report_value(s.name, "arlen", 0, 32'(mem0.last_arlen));
				assert (mem0.last_arburst == 2'd0)
					else report_value(s.name, "arburst", 0, 32'(mem0.last_arburst));
			end
			assert (pc == exp_pc) else report_value(s.name, "pc", exp_pc, pc);
			assert (inst == (exp_pc ^ MEM_KEY))
				else report_value(s.name, "inst", exp_pc ^ MEM_KEY, inst);
			if (s.redir_mode == 1 && i == s.redir_at) begin
				pulse_jump(s.redir_addr);
				exp_pc = s.redir_addr;
				continue;
			end
			if (s.stall_mask[i]) begin
				check_hold(s.name, 3);
			end
			idu_ready = 1'b1;
			@(negedge clock);
			idu_ready = 1'b0;
			exp_pc = exp_pc + 32'd4;
			if (s.redir_mode == 2 && i == s.redir_at) begin
				pulse_jump(s.redir_addr); // Next fetch still outstanding
				exp_pc = s.redir_addr;
			end
		end
		if (s.check_no_req) begin
			assert (mem0.req_count == start_count)
				else report_value(s.name, "request count", start_count, mem0.req_count);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		jump_wrong = 1'b0;
		jump_addr = '0;
		idu_ready = 1'b0;
		errors = 0;
		set_row(0, "boot_uncached", 0, `FETCH_RESET_PC, 6, 8'h04, 0, 0, 0, 0, 0);
		set_row(1, "sdram_miss", 1, 32'ha000_0104, 8, 8'h00, 0, 0, 0, 1, 0);
		set_row(2, "sdram_hit", 1, 32'ha000_0104, 8, 8'h00, 0, 0, 0, 0, 1);
		set_row(3, "stall_uncached", 1, 32'h3000_0200, 5, 8'h16, 0, 0, 0, 0, 0);
		set_row(4, "redirect_mid", 1, 32'ha000_0400, 6, 8'h00, 2, 1, 32'h3000_0800, 1, 0);
		set_row(5, "redirect_miss", 1, 32'ha000_1000, 6, 8'h00, 3, 2, 32'ha000_2008, 1, 0);
		set_row(6, "stall_sdram", 1, 32'ha000_1004, 4, 8'h0b, 0, 0, 0, 0, 0);
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// Boot fetch requested straight out of reset
		assert (arvalid) else report_value("reset", "arvalid", 1, 32'(arvalid));
		assert (!idu_valid) else report_value("reset", "idu_valid", 0, 32'(idu_valid));
		assert (rready) else report_value("reset", "rready", 1, 32'(rready));
		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
		end
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_with_fail();
		end
	end

endmodule

/* sim.f */
+incdir+src
src/fetch_pkg.sv
src/inst_cache.sv
src/fetch_unit.sv
src/fetch_top.sv
verif/bus_mem_model.sv
verif/fetch_tb.sv

/* Makefile */
# Verilator flow for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= sim.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_STR  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(wildcard src/*.sv src/*.svh verif/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
